/* Makefile */
TOP = tb_id_decode

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -f id_decode.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --top-module id_decode source/rv_isa_pkg.sv \
		source/ctrl_sel_pkg.sv source/id_ctrl_decode.sv source/id_imm_gen.sv \
		source/id_stage_reg.sv source/id_decode.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f id_decode.f

clean:
	rm -rf obj_dir sim.log

/* id_decode.f */
source/rv_isa_pkg.sv
source/ctrl_sel_pkg.sv
source/id_ctrl_decode.sv
source/id_imm_gen.sv
source/id_stage_reg.sv
source/id_decode.sv
tb/tb_id_decode_assert.sv
tb/tb_id_decode.sv

/* source/ctrl_sel_pkg.sv */
package ctrl_sel_pkg;

    // ========================================================================
    // PC and register write-back selects
    // ========================================================================

    typedef logic [1:0] pc_wr_sel_t;

    localparam pc_wr_sel_t PC_WR_NEXT = 2'd0;   // Sequential PC.
    localparam pc_wr_sel_t PC_WR_ALU  = 2'd1;   // ALU result is the target.
    localparam pc_wr_sel_t PC_WR_JALR = 2'd2;   // ALU result, bit 0 cleared.
    // Branch target taken only if the execute stage comparison holds.
    localparam pc_wr_sel_t PC_WR_COND = 2'd3;

    typedef logic [1:0] rd_wr_sel_t;

    localparam rd_wr_sel_t RD_WR_ALU      = 2'd0;
    localparam rd_wr_sel_t RD_WR_DRAM     = 2'd1;
    localparam rd_wr_sel_t RD_WR_PC_INC_4 = 2'd2;   // Link address.

    // ========================================================================
    // ALU operand and function selects
    // ========================================================================

    typedef logic [1:0] alu_a_sel_t;

    localparam alu_a_sel_t ALU_A_RS1  = 2'd0;
    localparam alu_a_sel_t ALU_A_PC   = 2'd1;
    localparam alu_a_sel_t ALU_A_ZERO = 2'd2;

    typedef logic [1:0] alu_b_sel_t;

    localparam alu_b_sel_t ALU_B_RS2  = 2'd0;
    localparam alu_b_sel_t ALU_B_IMM  = 2'd1;
    localparam alu_b_sel_t ALU_B_ZERO = 2'd2;

    // Same encoding as funct3.
    typedef logic [2:0] alu_op1_t;

    localparam alu_op1_t ALU_OP_1_ADD = 3'b000;

    localparam logic ALU_OP_0_ADD_SRL = 1'b0;   // Bit 30 clear.

    // ========================================================================
    // Data memory
    // ========================================================================

    // Byte, half or word, signed or unsigned, as funct3 encodes it.
    typedef logic [2:0] dram_sel_t;

endpackage

/* source/id_ctrl_decode.sv */
`timescale 1ns/1ps

module id_ctrl_decode (
    input  logic [1:0]                opcode_quad_i,
    input  rv_isa_pkg::opcode_grp_t   opcode_grp_i,
    input  rv_isa_pkg::funct3_t       funct3_i,
    input  logic                      inst_bit30_i,

    output logic                      pc_wr_en_o,
    output ctrl_sel_pkg::pc_wr_sel_t  pc_wr_sel_o,

    output logic                      rd_wr_en_o,
    output ctrl_sel_pkg::rd_wr_sel_t  rd_wr_sel_o,

    output ctrl_sel_pkg::alu_a_sel_t  alu_a_sel_o,
    output ctrl_sel_pkg::alu_b_sel_t  alu_b_sel_o,

    output logic                      alu_op_0_sel_o,
    output ctrl_sel_pkg::alu_op1_t    alu_op_1_sel_o,

    output logic                      dram_wr_en_o,

    output rv_isa_pkg::imm_fmt_t      imm_fmt_o
);

import rv_isa_pkg::*;
import ctrl_sel_pkg::*;

always_comb begin
    // Default row, also used for anything not decoded below.
    pc_wr_en_o     = 1'b1;
    pc_wr_sel_o    = PC_WR_NEXT;
    rd_wr_en_o     = 1'b0;
    rd_wr_sel_o    = RD_WR_ALU;
    alu_a_sel_o    = ALU_A_ZERO;
    alu_b_sel_o    = ALU_B_ZERO;
    alu_op_0_sel_o = ALU_OP_0_ADD_SRL;
    alu_op_1_sel_o = ALU_OP_1_ADD;
    dram_wr_en_o   = 1'b0;
    imm_fmt_o      = IMM_FMT_NONE;

    if (opcode_quad_i == OPCODE_QUAD_FULL) begin
        case (opcode_grp_i)
            OPCODE_G_OP_IMM: begin
                rd_wr_en_o     = 1'b1;
                alu_a_sel_o    = ALU_A_RS1;
                alu_b_sel_o    = ALU_B_IMM;
                // Bit 30 is SRAI only for shifts; for ADDI it is immediate data.
                alu_op_0_sel_o = inst_bit30_i & |funct3_i;
                alu_op_1_sel_o = funct3_i;
                imm_fmt_o      = IMM_FMT_I;
            end
            OPCODE_G_LUI: begin
                rd_wr_en_o  = 1'b1;
                alu_b_sel_o = ALU_B_IMM;   // Zero plus immediate.
                imm_fmt_o   = IMM_FMT_U;
            end
            OPCODE_G_AUIPC: begin
                rd_wr_en_o  = 1'b1;
                alu_a_sel_o = ALU_A_PC;
                alu_b_sel_o = ALU_B_IMM;
                imm_fmt_o   = IMM_FMT_U;
            end
            OPCODE_G_OP: begin
                rd_wr_en_o     = 1'b1;
                alu_a_sel_o    = ALU_A_RS1;
                alu_b_sel_o    = ALU_B_RS2;
                alu_op_0_sel_o = inst_bit30_i;   // SUB and SRA.
                alu_op_1_sel_o = funct3_i;
            end
            OPCODE_G_JAL: begin
                pc_wr_sel_o = PC_WR_ALU;
                rd_wr_en_o  = 1'b1;
                rd_wr_sel_o = RD_WR_PC_INC_4;
                alu_a_sel_o = ALU_A_PC;
                alu_b_sel_o = ALU_B_IMM;
                imm_fmt_o   = IMM_FMT_J;
            end
            OPCODE_G_JALR: begin
                pc_wr_sel_o = PC_WR_JALR;
                rd_wr_en_o  = 1'b1;
                rd_wr_sel_o = RD_WR_PC_INC_4;
                alu_a_sel_o = ALU_A_RS1;
                alu_b_sel_o = ALU_B_IMM;
                imm_fmt_o   = IMM_FMT_I;
            end
            OPCODE_G_BRANCH: begin
                pc_wr_sel_o = PC_WR_COND;   // Resolved in execute.
                alu_a_sel_o = ALU_A_PC;
                alu_b_sel_o = ALU_B_IMM;
                imm_fmt_o   = IMM_FMT_B;
            end
            OPCODE_G_LOAD: begin
                pc_wr_en_o  = 1'b0;   // Hold PC until the read returns.
                rd_wr_en_o  = 1'b1;
                rd_wr_sel_o = RD_WR_DRAM;
                alu_a_sel_o = ALU_A_RS1;
                alu_b_sel_o = ALU_B_IMM;
                imm_fmt_o   = IMM_FMT_I;
            end
            OPCODE_G_STORE: begin
                alu_a_sel_o  = ALU_A_RS1;
                alu_b_sel_o  = ALU_B_IMM;
                dram_wr_en_o = 1'b1;
                imm_fmt_o    = IMM_FMT_S;
            end
            default: begin
                // Unknown group keeps the default row.
                imm_fmt_o = IMM_FMT_NONE;
            end
        endcase
    end
end

endmodule

/* source/id_decode.sv */
`timescale 1ns/1ps

module id_decode #(
    parameter int XLEN = 32
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          inst_valid_i,
    input  logic [rv_isa_pkg::INST_W-1:0] inst_data_i,

    output logic                          valid_o,

    output logic                          pc_wr_en_o,
    output ctrl_sel_pkg::pc_wr_sel_t      pc_wr_sel_o,

    output logic                          rd_wr_en_o,
    output ctrl_sel_pkg::rd_wr_sel_t      rd_wr_sel_o,
    output rv_isa_pkg::reg_addr_t         rd_wr_addr_o,

    output rv_isa_pkg::reg_addr_t         rs1_rd_addr_o,
    output rv_isa_pkg::reg_addr_t         rs2_rd_addr_o,

    output ctrl_sel_pkg::alu_a_sel_t      alu_a_sel_o,
    output ctrl_sel_pkg::alu_b_sel_t      alu_b_sel_o,

    output rv_isa_pkg::funct3_t           alu_comp_sel_o,

    output logic                          alu_op_0_sel_o,
    output ctrl_sel_pkg::alu_op1_t        alu_op_1_sel_o,

    output logic                          dram_wr_en_o,
    output ctrl_sel_pkg::dram_sel_t       dram_wr_sel_o,
    output ctrl_sel_pkg::dram_sel_t       dram_rd_sel_o,

    output logic [XLEN-1:0]               imm_rd_data_o
);

import rv_isa_pkg::*;
import ctrl_sel_pkg::*;

// ============================================================================
// Instruction fields
// ============================================================================

logic [1:0]  opcode_quad;
opcode_grp_t opcode_grp;
reg_addr_t   rd;
reg_addr_t   rs1;
reg_addr_t   rs2;
funct3_t     funct3;

assign opcode_quad = inst_data_i[1:0];
assign opcode_grp  = inst_data_i[6:2];
assign rd          = inst_data_i[11:7];
assign funct3      = inst_data_i[14:12];
assign rs1         = inst_data_i[19:15];
assign rs2         = inst_data_i[24:20];

// Decoded, not yet registered.
logic        pc_wr_en;
pc_wr_sel_t  pc_wr_sel;
logic        rd_wr_en;
rd_wr_sel_t  rd_wr_sel;
alu_a_sel_t  alu_a_sel;
alu_b_sel_t  alu_b_sel;
logic        alu_op_0_sel;
alu_op1_t    alu_op_1_sel;
logic        dram_wr_en;
imm_fmt_t    imm_fmt;
logic [XLEN-1:0] imm;

funct3_t     funct3_r;

// ============================================================================
// Decode, immediate and stage register
// ============================================================================

id_ctrl_decode i_id_ctrl_decode (
    .opcode_quad_i  (opcode_quad),
    .opcode_grp_i   (opcode_grp),
    .funct3_i       (funct3),
    .inst_bit30_i   (inst_data_i[30]),
    .pc_wr_en_o     (pc_wr_en),
    .pc_wr_sel_o    (pc_wr_sel),
    .rd_wr_en_o     (rd_wr_en),
    .rd_wr_sel_o    (rd_wr_sel),
    .alu_a_sel_o    (alu_a_sel),
    .alu_b_sel_o    (alu_b_sel),
    .alu_op_0_sel_o (alu_op_0_sel),
    .alu_op_1_sel_o (alu_op_1_sel),
    .dram_wr_en_o   (dram_wr_en),
    .imm_fmt_o      (imm_fmt)
);

id_imm_gen #(
    .XLEN (XLEN)
) i_id_imm_gen (
    .inst_data_i (inst_data_i),
    .imm_fmt_i   (imm_fmt),
    .imm_o       (imm)
);

id_stage_reg #(
    .XLEN (XLEN)
) i_id_stage_reg (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (inst_valid_i),
    .pc_wr_en_i     (pc_wr_en),
    .pc_wr_sel_i    (pc_wr_sel),
    .rd_wr_en_i     (rd_wr_en),
    .rd_wr_sel_i    (rd_wr_sel),
    .alu_a_sel_i    (alu_a_sel),
    .alu_b_sel_i    (alu_b_sel),
    .alu_op_0_sel_i (alu_op_0_sel),
    .alu_op_1_sel_i (alu_op_1_sel),
    .dram_wr_en_i   (dram_wr_en),
    .rd_addr_i      (rd),
    .rs1_addr_i     (rs1),
    .rs2_addr_i     (rs2),
    .funct3_i       (funct3),
    .imm_i          (imm),
    .valid_o        (valid_o),
    .pc_wr_en_o     (pc_wr_en_o),
    .pc_wr_sel_o    (pc_wr_sel_o),
    .rd_wr_en_o     (rd_wr_en_o),
    .rd_wr_sel_o    (rd_wr_sel_o),
    .alu_a_sel_o    (alu_a_sel_o),
    .alu_b_sel_o    (alu_b_sel_o),
    .alu_op_0_sel_o (alu_op_0_sel_o),
    .alu_op_1_sel_o (alu_op_1_sel_o),
    .dram_wr_en_o   (dram_wr_en_o),
    .rd_addr_o      (rd_wr_addr_o),
    .rs1_addr_o     (rs1_rd_addr_o),
    .rs2_addr_o     (rs2_rd_addr_o),
    .funct3_o       (funct3_r),
    .imm_o          (imm_rd_data_o)
);

// Branch condition and access width both come straight from funct3.
assign alu_comp_sel_o = funct3_r;
assign dram_wr_sel_o  = funct3_r;
assign dram_rd_sel_o  = funct3_r;

endmodule

/* source/id_imm_gen.sv */
`timescale 1ns/1ps

module id_imm_gen #(
    parameter int XLEN = 32
) (
    input  logic [rv_isa_pkg::INST_W-1:0] inst_data_i,
    input  rv_isa_pkg::imm_fmt_t          imm_fmt_i,

    output logic [XLEN-1:0]               imm_o
);

import rv_isa_pkg::*;

logic                     sign_w;
logic signed [INST_W-1:0] imm_w;

assign sign_w = inst_data_i[INST_W-1];   // Every format takes its sign from bit 31.

// ============================================================================
// Reassemble the scattered immediate bits
// ============================================================================

always_comb begin
    case (imm_fmt_i)
        IMM_FMT_I: begin
            imm_w = {{21{sign_w}}, inst_data_i[30:20]};
        end
        IMM_FMT_S: begin
            imm_w = {{21{sign_w}}, inst_data_i[30:25], inst_data_i[11:7]};
        end
        IMM_FMT_B: begin
            imm_w = {{20{sign_w}}, inst_data_i[7], inst_data_i[30:25],
                     inst_data_i[11:8], 1'b0};
        end
        IMM_FMT_U: begin
            imm_w = {inst_data_i[31:12], 12'h000};
        end
        IMM_FMT_J: begin
            imm_w = {{12{sign_w}}, inst_data_i[19:12], inst_data_i[20],
                     inst_data_i[30:21], 1'b0};
        end
        default: begin
            imm_w = '0;
        end
    endcase
end

// Signed cast widens to XLEN with sign extension.
assign imm_o = XLEN'(imm_w);

endmodule

/* source/id_stage_reg.sv */
`timescale 1ns/1ps

module id_stage_reg #(
    parameter int XLEN = 32
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic                      valid_i,
    input  logic                      pc_wr_en_i,
    input  ctrl_sel_pkg::pc_wr_sel_t  pc_wr_sel_i,
    input  logic                      rd_wr_en_i,
    input  ctrl_sel_pkg::rd_wr_sel_t  rd_wr_sel_i,
    input  ctrl_sel_pkg::alu_a_sel_t  alu_a_sel_i,
    input  ctrl_sel_pkg::alu_b_sel_t  alu_b_sel_i,
    input  logic                      alu_op_0_sel_i,
    input  ctrl_sel_pkg::alu_op1_t    alu_op_1_sel_i,
    input  logic                      dram_wr_en_i,
    input  rv_isa_pkg::reg_addr_t     rd_addr_i,
    input  rv_isa_pkg::reg_addr_t     rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t     rs2_addr_i,
    input  rv_isa_pkg::funct3_t       funct3_i,
    input  logic [XLEN-1:0]           imm_i,

    output logic                      valid_o,
    output logic                      pc_wr_en_o,
    output ctrl_sel_pkg::pc_wr_sel_t  pc_wr_sel_o,
    output logic                      rd_wr_en_o,
    output ctrl_sel_pkg::rd_wr_sel_t  rd_wr_sel_o,
    output ctrl_sel_pkg::alu_a_sel_t  alu_a_sel_o,
    output ctrl_sel_pkg::alu_b_sel_t  alu_b_sel_o,
    output logic                      alu_op_0_sel_o,
    output ctrl_sel_pkg::alu_op1_t    alu_op_1_sel_o,
    output logic                      dram_wr_en_o,
    output rv_isa_pkg::reg_addr_t     rd_addr_o,
    output rv_isa_pkg::reg_addr_t     rs1_addr_o,
    output rv_isa_pkg::reg_addr_t     rs2_addr_o,
    output rv_isa_pkg::funct3_t       funct3_o,
    output logic [XLEN-1:0]           imm_o
);

import rv_isa_pkg::*;
import ctrl_sel_pkg::*;

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        valid_o        <= 1'b0;
        pc_wr_en_o     <= 1'b0;
        pc_wr_sel_o    <= PC_WR_NEXT;
        rd_wr_en_o     <= 1'b0;
        rd_wr_sel_o    <= RD_WR_ALU;
        alu_a_sel_o    <= ALU_A_RS1;
        alu_b_sel_o    <= ALU_B_RS2;
        alu_op_0_sel_o <= ALU_OP_0_ADD_SRL;
        alu_op_1_sel_o <= ALU_OP_1_ADD;
        dram_wr_en_o   <= 1'b0;
        rd_addr_o      <= REG_ZERO;
        rs1_addr_o     <= REG_ZERO;
        rs2_addr_o     <= REG_ZERO;
        funct3_o       <= '0;
        imm_o          <= '0;
    end else begin
        valid_o        <= valid_i;
        // An invalid cycle becomes a bubble with no side effects.
        pc_wr_en_o     <= pc_wr_en_i & valid_i;
        rd_wr_en_o     <= rd_wr_en_i & valid_i;
        dram_wr_en_o   <= dram_wr_en_i & valid_i;
        pc_wr_sel_o    <= pc_wr_sel_i;
        rd_wr_sel_o    <= rd_wr_sel_i;
        alu_a_sel_o    <= alu_a_sel_i;
        alu_b_sel_o    <= alu_b_sel_i;
        alu_op_0_sel_o <= alu_op_0_sel_i;
        alu_op_1_sel_o <= alu_op_1_sel_i;
        rd_addr_o      <= rd_addr_i;
        rs1_addr_o     <= rs1_addr_i;
        rs2_addr_o     <= rs2_addr_i;
        funct3_o       <= funct3_i;   // Comparison and memory widths.
        imm_o          <= imm_i;
    end
end

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ========================================================================
    // Instruction word
    // ========================================================================

    localparam int INST_W = 32;

    // Bits 1:0 of a 32-bit (non-compressed) instruction.
    localparam logic [1:0] OPCODE_QUAD_FULL = 2'b11;

    // ========================================================================
    // Field types
    // ========================================================================

    typedef logic [4:0] opcode_grp_t;   // Major opcode, bits 6:2.
    typedef logic [4:0] reg_addr_t;     // Register file index.
    typedef logic [2:0] funct3_t;       // Minor opcode, bits 14:12.

    localparam reg_addr_t REG_ZERO = 5'd0;

    // ========================================================================
    // Major opcode groups
    // ========================================================================

    localparam opcode_grp_t OPCODE_G_LOAD   = 5'b00000;
    localparam opcode_grp_t OPCODE_G_OP_IMM = 5'b00100;
    localparam opcode_grp_t OPCODE_G_AUIPC  = 5'b00101;
    localparam opcode_grp_t OPCODE_G_STORE  = 5'b01000;
    localparam opcode_grp_t OPCODE_G_OP     = 5'b01100;
    localparam opcode_grp_t OPCODE_G_LUI    = 5'b01101;
    localparam opcode_grp_t OPCODE_G_BRANCH = 5'b11000;
    localparam opcode_grp_t OPCODE_G_JALR   = 5'b11001;
    localparam opcode_grp_t OPCODE_G_JAL    = 5'b11011;

    // ========================================================================
    // Immediate formats
    // ========================================================================

    typedef logic [2:0] imm_fmt_t;

    localparam imm_fmt_t IMM_FMT_NONE = 3'd0;   // No immediate, reads as zero.
    localparam imm_fmt_t IMM_FMT_I    = 3'd1;   // Loads, OP-IMM, JALR.
    localparam imm_fmt_t IMM_FMT_S    = 3'd2;   // Stores.
    localparam imm_fmt_t IMM_FMT_B    = 3'd3;   // Branch offset, bit 0 zero.
    localparam imm_fmt_t IMM_FMT_U    = 3'd4;   // Upper 20 bits.
    localparam imm_fmt_t IMM_FMT_J    = 3'd5;   // Jump offset, bit 0 zero.

endpackage

/* tb/tb_id_decode.sv */
`timescale 1ns/1ps

module tb_id_decode;

import rv_isa_pkg::*;
import ctrl_sel_pkg::*;

localparam int CLK_PERIOD   = 20;
localparam int RESET_CYCLES = 8;
localparam int N_IMM        = 20;   // Words per immediate format.
localparam int N_ALU        = 16;
localparam int N_STREAM     = 48;
localparam int TEST_WORDS   = 9 + 5 * N_IMM + 2 * N_ALU + N_STREAM + 8 + 1;
localparam int WATCHDOG_NS  = (TEST_WORDS + RESET_CYCLES + 20) * CLK_PERIOD;

typedef struct packed {
    logic        valid;
    logic        pc_en;
    logic [1:0]  pc_sel;
    logic        rd_en;
    logic [1:0]  rd_sel;
    logic [4:0]  rd_addr;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [1:0]  a_sel;
    logic [1:0]  b_sel;
    logic [2:0]  comp_sel;
    logic        op0;
    logic [2:0]  op1;
    logic        dram_en;
    logic [2:0]  dram_wr_sel;
    logic [2:0]  dram_rd_sel;
    logic [31:0] imm;
} bundle_t;

logic        clk_i;
logic        rst_n_i;
logic        inst_valid_i;
logic [31:0] inst_data_i;
logic        valid_o;
logic        pc_wr_en_o;
pc_wr_sel_t  pc_wr_sel_o;
logic        rd_wr_en_o;
rd_wr_sel_t  rd_wr_sel_o;
reg_addr_t   rd_wr_addr_o;
reg_addr_t   rs1_rd_addr_o;
reg_addr_t   rs2_rd_addr_o;
alu_a_sel_t  alu_a_sel_o;
alu_b_sel_t  alu_b_sel_o;
funct3_t     alu_comp_sel_o;
logic        alu_op_0_sel_o;
alu_op1_t    alu_op_1_sel_o;
logic        dram_wr_en_o;
dram_sel_t   dram_wr_sel_o;
dram_sel_t   dram_rd_sel_o;
logic [31:0] imm_rd_data_o;

int          errors    = 0;
int          bundles   = 0;
logic [31:0] rng_state = 32'h9ef8;
bundle_t     exp_bundle;   // Expected outputs after the next edge.
logic [31:0] exp_word;

id_decode #(.XLEN(32)) i_id_decode (.*);

initial clk_i = 1'b0;
always #(CLK_PERIOD / 2) clk_i = ~clk_i;

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic logic [31:0] make_word(input opcode_grp_t grp, input logic [1:0] quad);
    logic [31:0] r;
    r = xorshift32();
    return {r[31:7], grp, quad};
endfunction

// ============================================================================
// Reference model
// ============================================================================

function automatic bundle_t expected_bundle(input logic valid, input logic [31:0] word);
    bundle_t     b;
    opcode_grp_t grp;
    funct3_t     f3;
    logic [9:0]  ctl;   // pc_en, pc_sel, rd_en, rd_sel, a_sel, b_sel.
    f3  = word[14:12];
    // A compressed quadrant decodes like an unknown group.
    grp = (word[1:0] == 2'b11) ? word[6:2] : 5'b11111;
    case (grp)
        OPCODE_G_LOAD:   ctl = {1'b0, PC_WR_NEXT, 1'b1, RD_WR_DRAM, ALU_A_RS1, ALU_B_IMM};
        OPCODE_G_OP_IMM: ctl = {1'b1, PC_WR_NEXT, 1'b1, RD_WR_ALU, ALU_A_RS1, ALU_B_IMM};
        OPCODE_G_AUIPC:  ctl = {1'b1, PC_WR_NEXT, 1'b1, RD_WR_ALU, ALU_A_PC, ALU_B_IMM};
        OPCODE_G_STORE:  ctl = {1'b1, PC_WR_NEXT, 1'b0, RD_WR_ALU, ALU_A_RS1, ALU_B_IMM};
        OPCODE_G_OP:     ctl = {1'b1, PC_WR_NEXT, 1'b1, RD_WR_ALU, ALU_A_RS1, ALU_B_RS2};
        OPCODE_G_LUI:    ctl = {1'b1, PC_WR_NEXT, 1'b1, RD_WR_ALU, ALU_A_ZERO, ALU_B_IMM};
        OPCODE_G_BRANCH: ctl = {1'b1, PC_WR_COND, 1'b0, RD_WR_ALU, ALU_A_PC, ALU_B_IMM};
        OPCODE_G_JALR:   ctl = {1'b1, PC_WR_JALR, 1'b1, RD_WR_PC_INC_4, ALU_A_RS1, ALU_B_IMM};
        OPCODE_G_JAL:    ctl = {1'b1, PC_WR_ALU, 1'b1, RD_WR_PC_INC_4, ALU_A_PC, ALU_B_IMM};
        default:         ctl = {1'b1, PC_WR_NEXT, 1'b0, RD_WR_ALU, ALU_A_ZERO, ALU_B_ZERO};
    endcase
    b = '0;   // Add, with no modifier.
    {b.pc_en, b.pc_sel, b.rd_en, b.rd_sel, b.a_sel, b.b_sel} = ctl;
    b.valid       = valid;
    b.pc_en       = b.pc_en & valid;
    b.rd_en       = b.rd_en & valid;
    b.dram_en     = valid && (grp == OPCODE_G_STORE);
    b.rd_addr     = word[11:7];
    b.rs1_addr    = word[19:15];
    b.rs2_addr    = word[24:20];
    b.comp_sel    = f3;
    b.dram_wr_sel = f3;
    b.dram_rd_sel = f3;
    if (grp == OPCODE_G_OP || grp == OPCODE_G_OP_IMM) begin
        b.op1 = f3;
        // Bit 30 of an ADDI is immediate data.
        b.op0 = word[30] && (grp == OPCODE_G_OP || f3 != 3'b000);
    end
    case (grp)
        OPCODE_G_OP_IMM, OPCODE_G_LOAD, OPCODE_G_JALR: b.imm = {{20{word[31]}}, word[31:20]};
        OPCODE_G_STORE: b.imm = {{20{word[31]}}, word[31:25], word[11:7]};
        OPCODE_G_BRANCH: b.imm = {{19{word[31]}}, word[31], word[7], word[30:25],
                                  word[11:8], 1'b0};
        OPCODE_G_LUI, OPCODE_G_AUIPC: b.imm = {word[31:12], 12'h000};
        OPCODE_G_JAL: b.imm = {{11{word[31]}}, word[31], word[19:12], word[20],
                               word[30:21], 1'b0};
        default: b.imm = 32'h0;
    endcase
    return b;
endfunction

// ============================================================================
// Drive and check
// ============================================================================

task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("MISMATCH %s: got 0x%08h, expected 0x%08h, word 0x%08h",
                 name, got, exp, exp_word);
    end
endtask

task automatic compare_outputs(input bundle_t e);
    bundles++;
    check_field("valid_o", 32'(valid_o), 32'(e.valid));
    check_field("pc_wr_en_o", 32'(pc_wr_en_o), 32'(e.pc_en));
    check_field("pc_wr_sel_o", 32'(pc_wr_sel_o), 32'(e.pc_sel));
    check_field("rd_wr_en_o", 32'(rd_wr_en_o), 32'(e.rd_en));
    check_field("rd_wr_sel_o", 32'(rd_wr_sel_o), 32'(e.rd_sel));
    check_field("rd_wr_addr_o", 32'(rd_wr_addr_o), 32'(e.rd_addr));
    check_field("rs1_rd_addr_o", 32'(rs1_rd_addr_o), 32'(e.rs1_addr));
    check_field("rs2_rd_addr_o", 32'(rs2_rd_addr_o), 32'(e.rs2_addr));
    check_field("alu_a_sel_o", 32'(alu_a_sel_o), 32'(e.a_sel));
    check_field("alu_b_sel_o", 32'(alu_b_sel_o), 32'(e.b_sel));
    check_field("alu_comp_sel_o", 32'(alu_comp_sel_o), 32'(e.comp_sel));
    check_field("alu_op_0_sel_o", 32'(alu_op_0_sel_o), 32'(e.op0));
    check_field("alu_op_1_sel_o", 32'(alu_op_1_sel_o), 32'(e.op1));
    check_field("dram_wr_en_o", 32'(dram_wr_en_o), 32'(e.dram_en));
    check_field("dram_wr_sel_o", 32'(dram_wr_sel_o), 32'(e.dram_wr_sel));
    check_field("dram_rd_sel_o", 32'(dram_rd_sel_o), 32'(e.dram_rd_sel));
    check_field("imm_rd_data_o", imm_rd_data_o, e.imm);
endtask

// One cycle: present a word and check the one presented a cycle earlier.
task automatic step(input logic valid, input logic [31:0] word);
    @(posedge clk_i);
    inst_valid_i <= valid;
    inst_data_i  <= word;
    @(negedge clk_i);
    compare_outputs(exp_bundle);
    exp_bundle = expected_bundle(valid, word);
    exp_word   = word;
endtask

task automatic apply_reset();
    logic [31:0] word;
    word     = 32'h0;
    exp_word = 32'h0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
        // Valid words with enables set, the stage must still stay empty.
        word = make_word(i[0] ? OPCODE_G_STORE : OPCODE_G_OP, 2'b11);
        @(posedge clk_i);
        inst_valid_i <= 1'b1;
        inst_data_i  <= word;
        if (i == RESET_CYCLES - 1) begin
            rst_n_i <= 1'b1;
        end
        @(negedge clk_i);
        compare_outputs('0);   // Every field clears.
    end
    exp_bundle = expected_bundle(1'b1, word);
    exp_word   = word;
endtask

task automatic test_control_table();
    step(1'b1, make_word(OPCODE_G_OP_IMM, 2'b11));
    step(1'b1, make_word(OPCODE_G_LUI, 2'b11));
    step(1'b1, make_word(OPCODE_G_AUIPC, 2'b11));
    step(1'b1, make_word(OPCODE_G_OP, 2'b11));
    step(1'b1, make_word(OPCODE_G_JAL, 2'b11));
    step(1'b1, make_word(OPCODE_G_JALR, 2'b11));
    step(1'b1, make_word(OPCODE_G_BRANCH, 2'b11));
    step(1'b1, make_word(OPCODE_G_LOAD, 2'b11));
    step(1'b1, make_word(OPCODE_G_STORE, 2'b11));
endtask

task automatic test_immediates();
    for (int i = 0; i < N_IMM; i++) begin
        step(1'b1, make_word(i[0] ? OPCODE_G_LOAD : OPCODE_G_JALR, 2'b11));
        step(1'b1, make_word(OPCODE_G_STORE, 2'b11));
        step(1'b1, make_word(OPCODE_G_BRANCH, 2'b11));
        step(1'b1, make_word(i[0] ? OPCODE_G_LUI : OPCODE_G_AUIPC, 2'b11));
        step(1'b1, make_word(OPCODE_G_JAL, 2'b11));
    end
endtask

task automatic test_alu_modifier();
    logic [31:0] word;
    for (int i = 0; i < N_ALU; i++) begin
        // Every funct3 with bit 30 clear and set.
        word        = make_word(OPCODE_G_OP, 2'b11);
        word[14:12] = i[2:0];
        word[30]    = i[3];
        step(1'b1, word);
        word        = make_word(OPCODE_G_OP_IMM, 2'b11);
        word[14:12] = i[2:0];
        word[30]    = i[3];
        step(1'b1, word);
    end
endtask

task automatic test_stream_bubbles();
    opcode_grp_t groups [9];
    logic [31:0] r;
    logic [3:0]  idx;
    groups = '{OPCODE_G_OP_IMM, OPCODE_G_LUI, OPCODE_G_AUIPC, OPCODE_G_OP, OPCODE_G_JAL,
               OPCODE_G_JALR, OPCODE_G_BRANCH, OPCODE_G_LOAD, OPCODE_G_STORE};
    for (int i = 0; i < N_STREAM; i++) begin
        r   = xorshift32();
        idx = r[31:28] % 4'd9;
        step(r[1:0] != 2'b00, make_word(groups[idx], 2'b11));   // About one in four is a bubble.
    end
endtask

task automatic test_default_decode();
    step(1'b1, make_word(5'b00011, 2'b11));   // MISC-MEM.
    step(1'b1, make_word(5'b11100, 2'b11));   // SYSTEM.
    step(1'b1, make_word(5'b01011, 2'b11));
    step(1'b1, make_word(5'b10100, 2'b11));
    step(1'b1, make_word(OPCODE_G_OP, 2'b00));
    step(1'b1, make_word(OPCODE_G_LOAD, 2'b01));
    step(1'b1, make_word(OPCODE_G_STORE, 2'b10));
    step(1'b1, make_word(OPCODE_G_JAL, 2'b00));
endtask

initial begin
    int assert_fails;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_data_i  = 32'h0;
    apply_reset();
    test_control_table();
    test_immediates();
    test_alu_modifier();
    test_stream_bubbles();
    test_default_decode();
    step(1'b0, 32'h0);   // Drains the last word.
    assert_fails = i_id_decode.i_id_stage_reg.i_tb_id_decode_assert.fail_count;
    $display("Errors: %0d mismatching fields in %0d checked bundles, %0d assertion failures",
             errors, bundles, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests were still running after %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
end

endmodule

/* tb/tb_id_decode_assert.sv */
`timescale 1ns/1ps

module tb_id_decode_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic valid_i,
    input logic pc_wr_en_i,
    input logic rd_wr_en_i,
    input logic dram_wr_en_i
);

int fail_count = 0;

// The cycle after a reset edge shows an empty stage.
a_reset_clears: assert property (
    @(posedge clk_i) !rst_n_i |=> !valid_i && !pc_wr_en_i && !rd_wr_en_i && !dram_wr_en_i
) else begin
    fail_count = fail_count + 1;
    $error("Stage outputs not cleared one cycle after reset.");
end

// A bubble carries no side effects.
a_bubble_quiet: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !valid_i |-> !pc_wr_en_i && !rd_wr_en_i && !dram_wr_en_i
) else begin
    fail_count = fail_count + 1;
    $error("An enable is high while the stage holds a bubble.");
end

a_store_no_rd: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) dram_wr_en_i |-> !rd_wr_en_i
) else begin
    fail_count = fail_count + 1;
    $error("A memory write also writes the register file.");
end

endmodule

bind id_stage_reg tb_id_decode_assert i_tb_id_decode_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_o),
    .pc_wr_en_i   (pc_wr_en_o),
    .rd_wr_en_i   (rd_wr_en_o),
    .dram_wr_en_i (dram_wr_en_o)
);
